//--- logic_analyzer.f
verilog/la_pkg.sv
verilog/la_trigger_unit.sv
verilog/la_sample_packer.sv
verilog/la_capture_ctrl.sv
verilog/la_sample_fifo.sv
verilog/la_burst_reader.sv
verilog/logic_analyzer.sv
verif/logic_analyzer_tb.sv

//--- verif/logic_analyzer_tb.sv
`default_nettype none

module logic_analyzer_tb import la_pkg::*; ();

    localparam int  CLK_PERIOD    = 10;
    localparam int  WAIT_LIMIT    = 4000;
    localparam int  RUN_CYCLES    = 10 + 4 * 63 + 600 + 40 + 2 * 4 * 300 + 600 + 512 + 200;
    localparam time WATCHDOG_TIME = 3 * RUN_CYCLES * CLK_PERIOD;
    localparam int  READY_HIGH    = 0;
    localparam int  READY_RANDOM  = 1;
    localparam int  READY_LOW     = 2;

    logic       clk;
    logic       rstn;
    logic       start;
    sample_t    digital_in;
    logic [7:0] clock_div;
    chan_sel_t  chan_sel;
    trig_mode_t trig_mode;
    sample_t    trig_mask;
    sample_t    trig_value;
    count_t     pre_load_num;
    count_t     load_num;
    logic       busy;
    logic       done;
    logic       overrun;
    logic       rd_burst_valid;
    logic       rd_burst_ready;
    logic [7:0] rd_burst;
    logic       rd_data_valid;
    logic       rd_data_ready;
    word_t      rd_data;
    logic       rd_data_last;

    sample_t     in_value;
    logic        ramp_en;
    int          ready_mode;
    word_t       word_q[$];
    logic [7:0]  burst_q[$];
    int          burst_left;
    logic        data_pending;
    word_t       pending_data;
    logic        burst_pending;
    logic [7:0]  pending_burst;
    int          errors;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;

    logic_analyzer dut_i (
        .clk(clk), .rstn(rstn), .digital_in(digital_in), .start(start),
        .clock_div(clock_div), .chan_sel(chan_sel), .trig_mode(trig_mode),
        .trig_mask(trig_mask), .trig_value(trig_value), .pre_load_num(pre_load_num),
        .load_num(load_num), .busy(busy), .done(done), .overrun(overrun),
        .rd_burst_valid(rd_burst_valid), .rd_burst_ready(rd_burst_ready),
        .rd_burst(rd_burst), .rd_data_valid(rd_data_valid),
        .rd_data_ready(rd_data_ready), .rd_data(rd_data), .rd_data_last(rd_data_last)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // input value or a ramp, plus the sink's ready lines
    initial begin
        void'($urandom(32'h75515a76));
        forever begin
            @(posedge clk);
            digital_in <= ramp_en ? digital_in + 32'd1 : in_value;
            case (ready_mode)
                READY_RANDOM: begin
                    rd_data_ready  <= $urandom_range(1, 0);
                    rd_burst_ready <= $urandom_range(1, 0);
                end
                READY_LOW: begin
                    rd_data_ready  <= 1'b0;
                    rd_burst_ready <= 1'b1;
                end
                default: begin
                    rd_data_ready  <= 1'b1;
                    rd_burst_ready <= 1'b1;
                end
            endcase
        end
    end

    task automatic report_mismatch(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    // scoreboard for both output streams
    always @(negedge clk) begin
        if (!rstn) begin
            burst_left    = 0;
            data_pending  = 1'b0;
            burst_pending = 1'b0;
        end else begin
            if (burst_pending && (!rd_burst_valid || rd_burst !== pending_burst))
                report_mismatch("burst descriptor dropped or changed before it was taken");
            if (data_pending && (!rd_data_valid || rd_data !== pending_data))
                report_mismatch("data beat dropped or changed before it was taken");
            if (rd_burst_valid && rd_burst_ready) begin
                if (burst_left != 0)
                    report_mismatch("burst descriptor inside an open burst");
                burst_q.push_back(rd_burst);
                burst_left = int'(rd_burst) + 1;
            end
            if (rd_data_valid && rd_data_ready) begin
                if (burst_left == 0)
                    report_mismatch("data beat without a burst descriptor");
                else
                    burst_left--;
                if (rd_data_last !== (burst_left == 0))
                    report_mismatch($sformatf("last flag %0b, expected %0b",
                                              rd_data_last, burst_left == 0));
                word_q.push_back(rd_data);
            end
            burst_pending = rd_burst_valid && !rd_burst_ready;
            pending_burst = rd_burst;
            data_pending  = rd_data_valid && !rd_data_ready;
            pending_data  = rd_data;
        end
    end

    function automatic int chan_width(input chan_sel_t sel);
        case (sel)
            CH_1:    return 1;
            CH_2:    return 2;
            CH_4:    return 4;
            CH_8:    return 8;
            CH_16:   return 16;
            default: return 32;
        endcase
    endfunction

    // low channels of the input repeated over the word
    function automatic word_t replicate(input sample_t value, input int width);
        word_t result;
        result = '0;
        for (int pos = 0; pos < WORD_W; pos += width)
            result |= word_t'(64'(value) & ((64'd1 << width) - 64'd1)) << pos;
        return result;
    endfunction

    task automatic begin_test();
        word_q.delete();
        burst_q.delete();
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        if (errors != errors_at_start) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_at_start);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic configure(input logic [7:0] div, input chan_sel_t sel,
                             input trig_mode_t mode, input sample_t trig,
                             input sample_t value, input count_t pre, input count_t load);
        @(posedge clk);
        clock_div    <= div;
        chan_sel     <= sel;
        trig_mode    <= mode;
        trig_mask    <= '1;
        trig_value   <= trig;
        in_value     <= value;
        pre_load_num <= pre;
        load_num     <= load;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done(input string name);
        int n;
        n = 1;
        @(negedge clk);
        while (!done && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!done)
            report_failure($sformatf("done never rose in %s within %0d cycles",
                                     name, WAIT_LIMIT));
    endtask

    task automatic check_count(input int expected);
        if (word_q.size() != expected)
            report_mismatch($sformatf("%0d words received, expected %0d",
                                      word_q.size(), expected));
    endtask

    task automatic check_all_equal(input word_t expected);
        foreach (word_q[i])
            if (word_q[i] !== expected)
                report_mismatch($sformatf("word %0d is %h, expected %h",
                                          i, word_q[i], expected));
    endtask

    task automatic check_ramp(input word_t step);
        for (int i = 1; i < word_q.size(); i++)
            if (word_q[i] !== word_q[i-1] + step)
                report_mismatch($sformatf("word %0d is %h after %h, out of order",
                                          i, word_q[i], word_q[i-1]));
    endtask

    task automatic check_bursts(input count_t load);
        count_t     rem;
        int         idx;
        logic [7:0] expect_len;
        rem = load;
        idx = 0;
        while (rem != 0) begin
            expect_len = (rem >= BURST_MAX) ? 8'(BURST_MAX - 1) : 8'(rem - 32'd1);
            if (idx >= burst_q.size())
                report_mismatch($sformatf("burst %0d missing", idx));
            else if (burst_q[idx] !== expect_len)
                report_mismatch($sformatf("burst %0d reads %0d, expected %0d",
                                          idx, burst_q[idx], expect_len));
            rem = rem - (count_t'(expect_len) + 32'd1);
            idx++;
        end
        if (burst_q.size() > idx)
            report_mismatch($sformatf("%0d burst descriptors, expected %0d",
                                      burst_q.size(), idx));
    endtask

    task automatic test_full_width();
        begin_test();
        configure(8'd0, CH_32, TRIG_FORCE, '0, 32'hA5C3_0F96, 32'd0, 32'd10);
        pulse_start();
        wait_done("full_width");
        check_count(10);
        check_all_equal(32'hA5C3_0F96);
        check_bursts(32'd10);
        end_test("full_width");
    endtask

    task automatic test_channel_packing();
        chan_sel_t sels[6] = '{CH_1, CH_2, CH_4, CH_8, CH_16, CH_32};
        begin_test();
        foreach (sels[i]) begin
            word_q.delete();
            burst_q.delete();
            configure(8'd0, sels[i], TRIG_FORCE, '0, 32'h3C96_E5A7, 32'd0, 32'd4);
            pulse_start();
            wait_done("channel_packing");
            check_count(4);
            check_all_equal(replicate(32'h3C96_E5A7, chan_width(sels[i])));
        end
        end_test("channel_packing");
    endtask

    task automatic test_burst_split();
        begin_test();
        configure(8'd0, CH_32, TRIG_FORCE, '0, 32'h0BAD_F00D, 32'd0, 32'd600);
        pulse_start();
        wait_done("burst_split");
        check_count(600);
        check_all_equal(32'h0BAD_F00D);
        check_bursts(32'd600);
        end_test("burst_split");
    endtask

    task automatic test_pretrigger();
        int   a_cnt;
        logic b_seen;
        a_cnt  = 0;
        b_seen = 1'b0;
        begin_test();
        configure(8'd0, CH_32, TRIG_LEVEL, 32'h0000_B00B, 32'h0000_AAAA, 32'd4, 32'd12);
        pulse_start();
        repeat (12) @(posedge clk);   // well over four history words
        in_value <= 32'h0000_B00B;
        wait_done("pretrigger");
        check_count(12);
        foreach (word_q[i]) begin
            if (word_q[i] === 32'h0000_AAAA) begin
                a_cnt++;
                if (b_seen)
                    report_mismatch($sformatf("history word %0d after the trigger", i));
            end else if (word_q[i] === 32'h0000_B00B) begin
                b_seen = 1'b1;
            end else begin
                report_mismatch($sformatf("word %0d is %h, neither history nor trigger",
                                          i, word_q[i]));
            end
        end
        if (a_cnt > 4)
            report_mismatch($sformatf("%0d history words, at most 4 expected", a_cnt));
        if (!b_seen)
            report_mismatch("no trigger value in the stream");
        check_bursts(32'd12);
        end_test("pretrigger");
    endtask

    task automatic test_random_ready();
        begin_test();
        configure(8'd3, CH_32, TRIG_FORCE, '0, '0, 32'd0, 32'd300);
        ramp_en    <= 1'b1;
        ready_mode <= READY_RANDOM;
        pulse_start();
        wait_done("random_ready");
        check_count(300);
        check_ramp(32'd4);   // one sample per four clocks
        check_bursts(32'd300);
        if (overrun !== 1'b0)
            report_mismatch("overrun set although the sink kept up");
        ready_mode <= READY_HIGH;
        end_test("random_ready");
    endtask

    task automatic test_overrun();
        int n;
        n = 0;
        begin_test();
        configure(8'd0, CH_32, TRIG_FORCE, '0, '0, 32'd0, 32'd600);
        ramp_en    <= 1'b1;
        ready_mode <= READY_LOW;
        pulse_start();
        while (!overrun && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!overrun)
            report_failure("overrun never rose while the sink was stalled");
        repeat (600 - FIFO_DEPTH + 8) @(posedge clk);   // rest of the capture
        ready_mode <= READY_HIGH;
        wait_done("overrun");
        check_count(FIFO_DEPTH);
        check_ramp(32'd1);
        if (overrun !== 1'b1)
            report_mismatch("overrun not held after the capture");
        end_test("overrun");
    endtask

    task automatic test_idle_reset();
        begin_test();
        @(posedge clk);
        ramp_en <= 1'b0;
        rstn    <= 1'b0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        if ({busy, done, overrun, rd_burst_valid, rd_data_valid} !== 5'b0)
            report_mismatch("status or valid outputs high after reset");
        configure(8'd0, CH_32, TRIG_OFF, '0, 32'h1234_5678, 32'd0, 32'd5);
        pulse_start();
        repeat (60) begin
            @(negedge clk);
            if (busy || rd_data_valid)
                report_mismatch("activity with the trigger switched off");
        end
        check_count(0);
        configure(8'd0, CH_32, TRIG_FORCE, '0, 32'h1234_5678, 32'd0, 32'd5);
        pulse_start();
        wait_done("idle_reset");
        check_count(5);
        check_all_equal(32'h1234_5678);
        end_test("idle_reset");
    endtask

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog timer ran out before the tests finished");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        clk            = 1'b0;
        rstn           = 1'b0;
        start          = 1'b0;
        digital_in     = '0;
        in_value       = '0;
        ramp_en        = 1'b0;
        ready_mode     = READY_HIGH;
        clock_div      = '0;
        chan_sel       = CH_32;
        trig_mode      = TRIG_OFF;
        trig_mask      = '0;
        trig_value     = '0;
        pre_load_num   = '0;
        load_num       = '0;
        rd_burst_ready = 1'b0;
        rd_data_ready  = 1'b0;
        errors         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;

        test_full_width();
        test_channel_packing();
        test_burst_split();
        test_pretrigger();
        test_random_ready();
        test_overrun();
        test_idle_reset();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/la_burst_reader.sv
`default_nettype none

module la_burst_reader import la_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       start,
    input  count_t     load_num,
    input  cap_state_t state,
    input  word_t      fifo_data,
    input  logic       fifo_empty,
    output logic       fifo_rd,
    output logic       read_finished,
    output logic       rd_burst_valid,
    input  logic       rd_burst_ready,
    output logic [7:0] rd_burst,
    output logic       rd_data_valid,
    input  logic       rd_data_ready,
    output word_t      rd_data,
    output logic       rd_data_last
);

    logic       active;
    logic       in_burst;
    logic [7:0] burst_left;
    count_t     remaining;
    logic       burst_xfer;
    logic       data_xfer;

    assign active = (state == ST_CAPTURE) || (state == ST_READ);

    // beats in the next burst minus one
    assign rd_burst = (remaining >= count_t'(BURST_MAX)) ? 8'(BURST_MAX - 1)
                                                         : remaining[7:0] - 8'd1;

    assign rd_burst_valid = active & ~in_burst & (remaining != '0);
    assign rd_data_valid  = active & in_burst & ~fifo_empty;
    assign rd_data        = fifo_data;
    assign rd_data_last   = rd_data_valid & (burst_left == 8'd0);

    assign burst_xfer    = rd_burst_valid & rd_burst_ready;
    assign data_xfer     = rd_data_valid & rd_data_ready;
    assign fifo_rd       = data_xfer;
    assign read_finished = data_xfer & (remaining == 32'd1);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            in_burst   <= 1'b0;
            burst_left <= '0;
            remaining  <= '0;
        end else if (start) begin
            in_burst   <= 1'b0;
            burst_left <= '0;
            remaining  <= load_num;
        end else if (!active) begin
            in_burst <= 1'b0;   // run ended or was cut short
        end else begin
            if (burst_xfer) begin
                in_burst   <= 1'b1;
                burst_left <= rd_burst;
            end
            if (data_xfer) begin
                remaining <= remaining - 32'd1;
                if (burst_left == 8'd0)
                    in_burst <= 1'b0;
                else
                    burst_left <= burst_left - 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/la_capture_ctrl.sv
`default_nettype none

module la_capture_ctrl import la_pkg::*; (
    input  logic             clk,
    input  logic             rstn,
    input  logic             start,
    input  trig_mode_t       trig_mode,
    input  count_t           pre_load_num,
    input  count_t           load_num,
    input  word_beat_t       word,
    input  logic [FIFO_AW:0] fifo_count,
    input  logic             fifo_full,
    input  logic             read_finished,
    output logic             fifo_wr,
    output logic             fifo_discard,
    output cap_state_t       state,
    output logic             busy,
    output logic             done,
    output logic             overrun
);

    cap_state_t state_d;
    cap_state_t cap_next;
    count_t     pre_lim;
    count_t     held_next;
    count_t     stored_cnt;
    logic       hit_now;

    // history must leave room for the trigger word
    always_comb begin
        pre_lim = pre_load_num;
        if (load_num == '0)
            pre_lim = '0;
        else if (pre_lim >= load_num)
            pre_lim = load_num - 32'd1;
        if (pre_lim > count_t'(FIFO_DEPTH - 1))
            pre_lim = count_t'(FIFO_DEPTH - 1);
    end

    assign hit_now   = word.hit | (trig_mode == TRIG_FORCE);
    assign held_next = count_t'(fifo_count) + 32'd1;
    assign cap_next  = (held_next >= load_num) ? ST_READ : ST_CAPTURE;

    always_comb begin
        state_d = state;
        case (state)
            ST_IDLE, ST_DONE: begin
                if (start) begin
                    if (trig_mode == TRIG_OFF)
                        state_d = ST_IDLE;   // disarmed
                    else if (pre_lim == '0)
                        state_d = ST_WAIT;
                    else
                        state_d = ST_PRELOAD;
                end
            end
            ST_PRELOAD: begin
                if (word.strobe && hit_now)
                    state_d = cap_next;
                else if (word.strobe && held_next >= pre_lim)
                    state_d = ST_WAIT;
            end
            ST_WAIT: begin
                if (word.strobe && hit_now)
                    state_d = cap_next;
            end
            ST_CAPTURE: begin
                if (word.strobe && (stored_cnt + 32'd1 >= load_num))
                    state_d = ST_READ;
            end
            ST_READ: begin
                // lost words can never arrive
                if (read_finished || (overrun && fifo_count == '0))
                    state_d = ST_DONE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_comb begin
        fifo_wr      = 1'b0;
        fifo_discard = 1'b0;
        if (word.strobe) begin
            case (state)
                ST_PRELOAD, ST_CAPTURE: fifo_wr = 1'b1;
                ST_WAIT: begin
                    fifo_wr      = hit_now | (pre_lim != '0);
                    fifo_discard = ~hit_now & (pre_lim != '0);   // drop oldest
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= ST_IDLE;
            stored_cnt <= '0;
            overrun    <= 1'b0;
        end else begin
            state <= state_d;
            if (start) begin
                stored_cnt <= '0;
                overrun    <= 1'b0;
            end else begin
                if (fifo_wr && fifo_full)
                    overrun <= 1'b1;
                if (fifo_wr) begin
                    if (state == ST_CAPTURE)
                        stored_cnt <= stored_cnt + 32'd1;
                    else if (hit_now)
                        stored_cnt <= held_next;   // history plus trigger word
                end
            end
        end
    end

    assign busy = (state == ST_CAPTURE) || (state == ST_READ);
    assign done = (state == ST_DONE);

    a_discard_keeps_level: assert property (@(posedge clk) disable iff (!rstn)
        fifo_discard |-> (state == ST_WAIT) ##1 (fifo_count == $past(fifo_count)))
        else $error("pre-trigger discard outside wait or fifo level moved");

    a_no_write_in_read: assert property (@(posedge clk) disable iff (!rstn)
        (state == ST_READ) |-> !fifo_wr)
        else $error("fifo write after capture ended");

endmodule

`default_nettype wire

//--- verilog/la_pkg.sv
`default_nettype none

package la_pkg;

    localparam int SAMPLE_W   = 32;
    localparam int WORD_W     = 32;
    localparam int FIFO_DEPTH = 512;
    localparam int FIFO_AW    = 9;
    localparam int BURST_MAX  = 256;

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [31:0]         count_t;

    // codes 6 and 7 behave as CH_32
    typedef enum logic [2:0] {
        CH_1  = 3'd0,
        CH_2  = 3'd1,
        CH_4  = 3'd2,
        CH_8  = 3'd3,
        CH_16 = 3'd4,
        CH_32 = 3'd5
    } chan_sel_t;

    typedef enum logic [1:0] {
        TRIG_OFF   = 2'd0,
        TRIG_LEVEL = 2'd1,
        TRIG_EDGE  = 2'd2,
        TRIG_FORCE = 2'd3
    } trig_mode_t;

    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_PRELOAD = 3'd1,
        ST_WAIT    = 3'd2,
        ST_CAPTURE = 3'd3,
        ST_READ    = 3'd4,
        ST_DONE    = 3'd5
    } cap_state_t;

    typedef struct packed {
        logic    strobe;
        logic    hit;
        sample_t data;
    } sample_beat_t;

    typedef struct packed {
        logic  strobe;
        logic  hit;   // trigger seen on any sample of the word
        word_t data;
    } word_beat_t;

    typedef struct packed {
        logic [7:0] clock_div;
        chan_sel_t  chan_sel;
        trig_mode_t trig_mode;
        sample_t    trig_mask;
        sample_t    trig_value;
        count_t     pre_load_num;
        count_t     load_num;
    } la_config_t;

endpackage

`default_nettype wire

//--- verilog/la_sample_fifo.sv
`default_nettype none

module la_sample_fifo import la_pkg::*; (
    input  logic             clk,
    input  logic             rstn,
    input  logic             clear,
    input  logic             wr,
    input  word_t            wr_data,
    input  logic             rd,
    output word_t            rd_data,
    output logic [FIFO_AW:0] count,
    output logic             empty,
    output logic             full
);

    word_t              mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   cnt_q;
    logic               wr_ok;
    logic               rd_ok;

    assign empty = (cnt_q == '0);
    assign full  = (cnt_q == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign count = cnt_q;

    assign wr_ok = wr & ~full;   // a write into a full fifo is lost
    assign rd_ok = rd & ~empty;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt_q  <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt_q  <= '0;
        end else begin
            if (wr_ok)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_ok)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_ok, rd_ok})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok && !clear)
            mem[wr_ptr] <= wr_data;
    end

    // head word shows ahead of the read
    assign rd_data = mem[rd_ptr];

    a_no_read_empty: assert property (@(posedge clk) disable iff (!rstn)
        rd |-> !empty)
        else $error("read of an empty sample fifo");

endmodule

`default_nettype wire

//--- verilog/la_sample_packer.sv
`default_nettype none

module la_sample_packer import la_pkg::*; (
    input  logic         clk,
    input  logic         rstn,
    input  logic         start,
    input  chan_sel_t    chan_sel,
    input  sample_beat_t beat,
    output word_beat_t   word
);

    logic [4:0] last_idx;
    logic [4:0] smp_cnt;
    logic       hit_acc;
    logic       word_done;
    logic       strobe_q;
    logic       hit_q;
    word_t      acc_q;
    word_t      shifted;

    // samples per word minus one
    always_comb begin
        case (chan_sel)
            CH_1:    last_idx = 5'd31;
            CH_2:    last_idx = 5'd15;
            CH_4:    last_idx = 5'd7;
            CH_8:    last_idx = 5'd3;
            CH_16:   last_idx = 5'd1;
            default: last_idx = 5'd0;
        endcase
    end

    // new sample enters at the top, oldest drifts to bit 0
    always_comb begin
        case (chan_sel)
            CH_1:    shifted = {beat.data[0], acc_q[WORD_W-1:1]};
            CH_2:    shifted = {beat.data[1:0], acc_q[WORD_W-1:2]};
            CH_4:    shifted = {beat.data[3:0], acc_q[WORD_W-1:4]};
            CH_8:    shifted = {beat.data[7:0], acc_q[WORD_W-1:8]};
            CH_16:   shifted = {beat.data[15:0], acc_q[WORD_W-1:16]};
            default: shifted = beat.data;
        endcase
    end

    assign word_done = beat.strobe && (smp_cnt >= last_idx);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            smp_cnt  <= '0;
            hit_acc  <= 1'b0;
            strobe_q <= 1'b0;
            hit_q    <= 1'b0;
        end else if (start) begin
            smp_cnt  <= '0;
            hit_acc  <= 1'b0;
            strobe_q <= 1'b0;
            hit_q    <= 1'b0;
        end else begin
            strobe_q <= word_done;
            hit_q    <= word_done & (hit_acc | beat.hit);
            if (beat.strobe) begin
                smp_cnt <= word_done ? 5'd0 : smp_cnt + 5'd1;
                hit_acc <= ~word_done & (hit_acc | beat.hit);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            acc_q <= '0;
        else if (beat.strobe)
            acc_q <= shifted;
    end

    assign word = '{strobe: strobe_q, hit: hit_q, data: acc_q};

endmodule

`default_nettype wire

//--- verilog/la_trigger_unit.sv
`default_nettype none

module la_trigger_unit import la_pkg::*; (
    input  logic         clk,
    input  logic         rstn,
    input  logic         start,
    input  la_config_t   cfg,
    input  sample_t      digital_in,
    output sample_beat_t beat
);

    logic [7:0] div_cnt;
    logic       tick;
    logic       match;
    logic       match_prev;
    logic       hit_d;
    logic       strobe_q;
    logic       hit_q;
    sample_t    data_q;

    assign tick  = (div_cnt >= cfg.clock_div);
    assign match = (((digital_in ^ cfg.trig_value) & cfg.trig_mask) == '0);

    always_comb begin
        case (cfg.trig_mode)
            TRIG_LEVEL: hit_d = match;
            TRIG_EDGE:  hit_d = match & ~match_prev;
            default:    hit_d = 1'b0;   // force is taken in the controller
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            div_cnt    <= '0;
            strobe_q   <= 1'b0;
            hit_q      <= 1'b0;
            match_prev <= 1'b1;
        end else if (start) begin
            div_cnt    <= '0;
            strobe_q   <= 1'b0;
            hit_q      <= 1'b0;
            match_prev <= 1'b1;   // no edge on the first tick
        end else begin
            div_cnt  <= tick ? 8'd0 : div_cnt + 8'd1;
            strobe_q <= tick;
            hit_q    <= tick & hit_d;
            if (tick)
                match_prev <= match;
        end
    end

    always_ff @(posedge clk) begin
        if (tick)
            data_q <= digital_in;
    end

    assign beat = '{strobe: strobe_q, hit: hit_q, data: data_q};

    a_tick_spacing: assert property (@(posedge clk) disable iff (!rstn)
        (beat.strobe && cfg.clock_div != 8'd0) |=> !beat.strobe)
        else $error("sample strobe on back-to-back cycles with divider set");

endmodule

`default_nettype wire

//--- verilog/logic_analyzer.sv
`default_nettype none

module logic_analyzer import la_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  sample_t    digital_in,
    input  logic       start,
    input  logic [7:0] clock_div,
    input  chan_sel_t  chan_sel,
    input  trig_mode_t trig_mode,
    input  sample_t    trig_mask,
    input  sample_t    trig_value,
    input  count_t     pre_load_num,
    input  count_t     load_num,
    output logic       busy,
    output logic       done,
    output logic       overrun,
    output logic       rd_burst_valid,
    input  logic       rd_burst_ready,
    output logic [7:0] rd_burst,
    output logic       rd_data_valid,
    input  logic       rd_data_ready,
    output word_t      rd_data,
    output logic       rd_data_last
);

    la_config_t       cfg;
    logic             start_ok;
    sample_beat_t     sample_beat;
    word_beat_t       word_beat;
    cap_state_t       cap_state;
    logic             fifo_wr;
    logic             fifo_discard;
    logic             reader_rd;
    word_t            fifo_data;
    logic [FIFO_AW:0] fifo_count;
    logic             fifo_empty;
    logic             fifo_full;
    logic             read_finished;

    assign cfg = '{
        clock_div:    clock_div,
        chan_sel:     chan_sel,
        trig_mode:    trig_mode,
        trig_mask:    trig_mask,
        trig_value:   trig_value,
        pre_load_num: pre_load_num,
        load_num:     load_num
    };

    // start only counts while no capture is running
    assign start_ok = start & ((cap_state == ST_IDLE) | (cap_state == ST_DONE));

    la_trigger_unit trigger_i (
        .clk(clk), .rstn(rstn), .start(start_ok), .cfg(cfg),
        .digital_in(digital_in), .beat(sample_beat)
    );

    la_sample_packer packer_i (
        .clk(clk), .rstn(rstn), .start(start_ok), .chan_sel(cfg.chan_sel),
        .beat(sample_beat), .word(word_beat)
    );

    la_capture_ctrl ctrl_i (
        .clk(clk), .rstn(rstn), .start(start_ok), .trig_mode(cfg.trig_mode),
        .pre_load_num(cfg.pre_load_num), .load_num(cfg.load_num), .word(word_beat),
        .fifo_count(fifo_count), .fifo_full(fifo_full), .read_finished(read_finished),
        .fifo_wr(fifo_wr), .fifo_discard(fifo_discard), .state(cap_state),
        .busy(busy), .done(done), .overrun(overrun)
    );

    // discard and read live in different states
    la_sample_fifo fifo_i (
        .clk(clk), .rstn(rstn), .clear(start_ok), .wr(fifo_wr), .wr_data(word_beat.data),
        .rd(fifo_discard | reader_rd), .rd_data(fifo_data), .count(fifo_count),
        .empty(fifo_empty), .full(fifo_full)
    );

    la_burst_reader reader_i (
        .clk(clk), .rstn(rstn), .start(start_ok), .load_num(cfg.load_num),
        .state(cap_state), .fifo_data(fifo_data), .fifo_empty(fifo_empty),
        .fifo_rd(reader_rd), .read_finished(read_finished),
        .rd_burst_valid(rd_burst_valid), .rd_burst_ready(rd_burst_ready),
        .rd_burst(rd_burst), .rd_data_valid(rd_data_valid),
        .rd_data_ready(rd_data_ready), .rd_data(rd_data), .rd_data_last(rd_data_last)
    );

endmodule

`default_nettype wire
